//--- hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

	//////////////////////////////
	// Widths
	localparam int xlen  = 32;	// Datapath width
	localparam int pc_w  = 12;	// PC width, 4 KiB code space
	localparam int reg_w = 5;	// Register index

	//////////////////////////////
	// Major opcodes, RV32I subset
	localparam logic [6:0] op_op     = 7'b0110011;	// Reg-reg ALU
	localparam logic [6:0] op_imm    = 7'b0010011;	// Reg-imm ALU and shifts
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;

	// ALU funct3
	localparam logic [2:0] f3_add  = 3'h0;	// Also sub
	localparam logic [2:0] f3_sll  = 3'h1;
	localparam logic [2:0] f3_slt  = 3'h2;
	localparam logic [2:0] f3_sltu = 3'h3;
	localparam logic [2:0] f3_xor  = 3'h4;
	localparam logic [2:0] f3_srl  = 3'h5;	// Also sra
	localparam logic [2:0] f3_or   = 3'h6;
	localparam logic [2:0] f3_and  = 3'h7;

	// Branch conditions
	localparam logic [2:0] f3_beq  = 3'h0;
	localparam logic [2:0] f3_bne  = 3'h1;
	localparam logic [2:0] f3_blt  = 3'h4;
	localparam logic [2:0] f3_bge  = 3'h5;
	localparam logic [2:0] f3_bltu = 3'h6;
	localparam logic [2:0] f3_bgeu = 3'h7;

	// funct7
	localparam logic [6:0] f7_base = 7'h00;
	localparam logic [6:0] f7_alt  = 7'h20;	// sub, sra, srai

	//////////////////////////////
	// Control encodings
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
		alu_xor, alu_srl, alu_sra, alu_or, alu_and
	} alu_op_e;

	typedef enum logic [1:0] {
		sel_pc4 = 2'd0,	// Link value
		sel_alu = 2'd1,
		sel_imm = 2'd2	// LUI
	} sel_data_e;

	typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_sel_e;

	//////////////////////////////
	// Instruction formats, MSB first
	typedef struct packed {
		logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
		logic [2:0] funct3; logic [4:0] rd;  logic [6:0] opcode;
	} r_fmt_t;
	typedef struct packed {
		logic [11:0] imm_11_0; logic [4:0] rs1; logic [2:0] funct3;
		logic [4:0]  rd;       logic [6:0] opcode;
	} i_fmt_t;
	typedef struct packed {
		logic [6:0] imm_11_5; logic [4:0] rs2; logic [4:0] rs1;
		logic [2:0] funct3;   logic [4:0] imm_4_0; logic [6:0] opcode;
	} s_fmt_t;
	typedef struct packed {
		logic imm_12; logic [5:0] imm_10_5; logic [4:0] rs2; logic [4:0] rs1;
		logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11; logic [6:0] opcode;
	} b_fmt_t;
	typedef struct packed {
		logic [19:0] imm_31_12; logic [4:0] rd; logic [6:0] opcode;
	} u_fmt_t;
	typedef struct packed {
		logic imm_20; logic [9:0] imm_10_1; logic imm_11; logic [7:0] imm_19_12;
		logic [4:0] rd; logic [6:0] opcode;
	} j_fmt_t;

	// One word, six views
	typedef union packed {
		r_fmt_t r_fmt; i_fmt_t i_fmt; s_fmt_t s_fmt;
		b_fmt_t b_fmt; u_fmt_t u_fmt; j_fmt_t j_fmt;
	} inst_u;

	//////////////////////////////
	// Decoded control, carried into EXE
	typedef struct packed {
		alu_op_e   alu_op;
		logic      sel_opa;		// 0 PC, 1 rs1
		logic      sel_opb;		// 0 rs2, 1 imm
		imm_sel_e  imm_sel;
		sel_data_e sel_data;
		logic      wr_en;
		logic      is_branch;
		logic [2:0] br_cond;	// Branch funct3
		logic      is_jump;		// JAL or JALR
		logic      is_jalr;
		logic      illegal;
	} ctrl_t;

	// Unit output
	typedef struct packed {
		logic [reg_w-1:0] rd;
		logic             wr_en;
		logic [xlen-1:0]  wr_data;
		logic             redirect;	// Taken branch or jump
		logic [pc_w-1:0]  target;
		logic             illegal;
	} result_t;

endpackage

`default_nettype wire

//--- hdl/alu.sv
`default_nettype none

module alu (
	input  wire [rv_pkg::xlen-1:0] op_a,
	input  wire [rv_pkg::xlen-1:0] op_b,
	input  wire rv_pkg::alu_op_e   alu_op,
	output logic [rv_pkg::xlen-1:0] result,
	output logic                    zero,	// Result all zeros
	output logic                    less	// Compare outcome
);
	import rv_pkg::*;

	logic [4:0] shamt;		// Low five bits of op_b
	logic       lt_s;
	logic       lt_u;

	assign shamt = op_b[4:0];
	assign lt_s  = $signed(op_a) < $signed(op_b);
	assign lt_u  = op_a < op_b;

	always_comb begin
		case (alu_op)
			alu_add:  result = op_a + op_b;
			alu_sub:  result = op_a - op_b;
			alu_sll:  result = op_a << shamt;
			alu_slt:  result = {{(xlen-1){1'b0}}, lt_s};
			alu_sltu: result = {{(xlen-1){1'b0}}, lt_u};
			alu_xor:  result = op_a ^ op_b;
			alu_srl:  result = op_a >> shamt;
			alu_sra:  result = $signed(op_a) >>> shamt;	// Arithmetic
			alu_or:   result = op_a | op_b;
			alu_and:  result = op_a & op_b;
			default:  result = '0;
		endcase
	end

	//////////////////////////////
	// Branch flags

	assign zero = (result == '0);	// beq, bne

	// Only meaningful for the compare ops
	always_comb begin
		case (alu_op)
			alu_slt, alu_sltu: less = result[0];
			default:           less = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/inst_decoder.sv
`default_nettype none

module inst_decoder (
	input  wire rv_pkg::inst_u inst,
	output rv_pkg::ctrl_t      ctrl
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       rd_nz;		// Writes to x0 are dropped

	assign opcode = inst.r_fmt.opcode;
	assign funct3 = inst.r_fmt.funct3;
	assign funct7 = inst.r_fmt.funct7;
	assign rd_nz  = (inst.r_fmt.rd != '0);

	// ALU op from funct3, alt picks sub or sra
	function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
		case (f3)
			f3_add:  return alt ? alu_sub : alu_add;
			f3_sll:  return alu_sll;
			f3_slt:  return alu_slt;
			f3_sltu: return alu_sltu;
			f3_xor:  return alu_xor;
			f3_srl:  return alt ? alu_sra : alu_srl;
			f3_or:   return alu_or;
			default: return alu_and;
		endcase
	endfunction

	always_comb begin
		ctrl          = '0;
		ctrl.alu_op   = alu_add;
		ctrl.sel_opa  = 1'b1;		// rs1 unless told otherwise
		ctrl.sel_opb  = 1'b1;		// Immediate
		ctrl.imm_sel  = imm_i;
		ctrl.sel_data = sel_alu;
		case (opcode)
			op_op: begin
				ctrl.sel_opb = 1'b0;
				ctrl.wr_en   = 1'b1;
				ctrl.alu_op  = alu_from_f3(funct3, funct7 == f7_alt);
				// Only add and srl have an alternate form
				if (funct7 == f7_alt)
					ctrl.illegal = (funct3 != f3_add) && (funct3 != f3_srl);
				else if (funct7 != f7_base)
					ctrl.illegal = 1'b1;
			end
			op_imm: begin
				ctrl.wr_en  = 1'b1;
				ctrl.alu_op = alu_from_f3(funct3, (funct3 == f3_srl) && (funct7 == f7_alt));
				// funct7 is shamt-adjacent only for shifts
				if (funct3 == f3_sll)
					ctrl.illegal = (funct7 != f7_base);
				else if (funct3 == f3_srl)
					ctrl.illegal = (funct7 != f7_base) && (funct7 != f7_alt);
			end
			op_lui: begin
				ctrl.imm_sel  = imm_u;
				ctrl.sel_data = sel_imm;	// Immediate goes straight out
				ctrl.wr_en    = 1'b1;
			end
			op_auipc: begin
				ctrl.sel_opa = 1'b0;		// PC + imm in the ALU
				ctrl.imm_sel = imm_u;
				ctrl.wr_en   = 1'b1;
			end
			op_branch: begin
				ctrl.sel_opb   = 1'b0;		// Compare rs1 with rs2
				ctrl.imm_sel   = imm_b;
				ctrl.is_branch = 1'b1;
				ctrl.br_cond   = funct3;
				case (funct3)
					f3_blt, f3_bge:   ctrl.alu_op = alu_slt;
					f3_bltu, f3_bgeu: ctrl.alu_op = alu_sltu;
					default:          ctrl.alu_op = alu_sub;	// beq, bne via zero
				endcase
			end
			op_jal: begin
				ctrl.imm_sel  = imm_j;
				ctrl.sel_data = sel_pc4;
				ctrl.is_jump  = 1'b1;
				ctrl.wr_en    = 1'b1;
			end
			op_jalr: begin
				ctrl.sel_data = sel_pc4;	// Link, target from rs1
				ctrl.is_jump  = 1'b1;
				ctrl.is_jalr  = 1'b1;
				ctrl.wr_en    = 1'b1;
			end
			default: ctrl.illegal = 1'b1;	// Unknown major opcode
		endcase
		ctrl.wr_en = ctrl.wr_en && rd_nz && !ctrl.illegal;
	end

endmodule

`default_nettype wire

//--- hdl/imm_gen.sv
`default_nettype none

module imm_gen (
	input  wire rv_pkg::inst_u    inst,
	input  wire rv_pkg::imm_sel_e imm_sel,
	output logic [rv_pkg::xlen-1:0] imm
);
	import rv_pkg::*;

	logic sign;		// Always inst[31]

	assign sign = inst.r_fmt.funct7[6];

	// Unshuffle the immediate bits
	always_comb begin
		case (imm_sel)
			imm_i: imm = {{(xlen-12){sign}}, inst.i_fmt.imm_11_0};
			imm_s: imm = {{(xlen-12){sign}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
			imm_b: begin
				// Halfword aligned offset
				imm = {{(xlen-12){sign}},
					inst.b_fmt.imm_11,
					inst.b_fmt.imm_10_5,
					inst.b_fmt.imm_4_1,
					1'b0};
			end
			imm_u: imm = {inst.u_fmt.imm_31_12, 12'h000};	// Upper 20, zeros below
			imm_j: begin
				imm = {{(xlen-20){sign}},
					inst.j_fmt.imm_19_12,
					inst.j_fmt.imm_11,
					inst.j_fmt.imm_10_1,
					1'b0};
			end
			default: imm = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/exe_stage.sv
`default_nettype none

module exe_stage (
	input  wire                        CLK,
	input  wire                        rst,
	input  wire                        in_valid,
	input  wire rv_pkg::ctrl_t         ctrl,
	input  wire [rv_pkg::xlen-1:0]     imm,
	input  wire [rv_pkg::xlen-1:0]     rs1_data,
	input  wire [rv_pkg::xlen-1:0]     rs2_data,
	input  wire [rv_pkg::pc_w-1:0]     pc,
	input  wire [rv_pkg::reg_w-1:0]    rd,
	output logic                       out_valid,
	output rv_pkg::result_t            res
);
	import rv_pkg::*;

	// ID/EXE payload
	typedef struct packed {
		ctrl_t            ctrl;
		logic [xlen-1:0]  imm;
		logic [xlen-1:0]  rs1;
		logic [xlen-1:0]  rs2;
		logic [pc_w-1:0]  pc;
		logic [reg_w-1:0] rd;
	} id_exe_t;

	id_exe_t         ie;
	logic            ie_valid;
	logic [xlen-1:0] pc_ext;		// PC widened to datapath
	logic [xlen-1:0] op_a, op_b;
	logic [xlen-1:0] alu_res;
	logic            alu_zero, alu_less;
	logic            taken;
	logic [xlen-1:0] tgt_sum;
	logic [pc_w-1:0] pc4;
	result_t         res_d;

	//////////////////////////////
	// ID/EXE register
	always_ff @(posedge CLK) begin
		if (rst) ie_valid <= 1'b0;
		else     ie_valid <= in_valid;
	end

	always_ff @(posedge CLK) ie <= '{ctrl, imm, rs1_data, rs2_data, pc, rd};	// No reset on payload

	//////////////////////////////
	// Execute
	assign pc_ext = {{(xlen-pc_w){1'b0}}, ie.pc};
	assign op_a   = ie.ctrl.sel_opa ? ie.rs1 : pc_ext;	// AUIPC uses PC
	assign op_b   = ie.ctrl.sel_opb ? ie.imm : ie.rs2;

	alu u_alu (
		.op_a   (op_a),
		.op_b   (op_b),
		.alu_op (ie.ctrl.alu_op),
		.result (alu_res),
		.zero   (alu_zero),
		.less   (alu_less)
	);

	// Branch resolution
	always_comb begin
		case (ie.ctrl.br_cond)
			f3_beq:          taken = alu_zero;
			f3_bne:          taken = !alu_zero;
			f3_blt, f3_bltu: taken = alu_less;
			f3_bge, f3_bgeu: taken = !alu_less;
			default:         taken = 1'b0;	// Reserved conditions never branch
		endcase
	end

	assign tgt_sum = (ie.ctrl.is_jalr ? ie.rs1 : pc_ext) + ie.imm;	// Target adder
	assign pc4     = ie.pc + pc_w'(4);

	always_comb begin
		res_d          = '0;
		res_d.rd       = ie.rd;
		res_d.wr_en    = ie_valid && ie.ctrl.wr_en;
		res_d.redirect = ie_valid && ((ie.ctrl.is_branch && taken) || ie.ctrl.is_jump);
		res_d.target   = {tgt_sum[pc_w-1:1], tgt_sum[0] & !ie.ctrl.is_jalr};
		res_d.illegal  = ie_valid && ie.ctrl.illegal;
		case (ie.ctrl.sel_data)
			sel_pc4: res_d.wr_data = {{(xlen-pc_w){1'b0}}, pc4};	// Link
			sel_imm: res_d.wr_data = ie.imm;
			default: res_d.wr_data = alu_res;
		endcase
	end

	//////////////////////////////
	// Output register
	always_ff @(posedge CLK) begin
		if (rst) begin
			out_valid    <= 1'b0;
			res.wr_en    <= 1'b0;
			res.redirect <= 1'b0;
		end else begin
			out_valid <= ie_valid;
			res       <= res_d;
		end
	end

	// Both pipeline valids cleared by reset
	a_quiet_after_rst: assert property (@(posedge CLK) rst |=> !out_valid ##1 !out_valid)
		else $error("out_valid high in the cycles after reset");

	// Decoded offsets keep redirects halfword aligned
	a_tgt_aligned: assert property (@(posedge CLK) disable iff (rst)
		out_valid && res.redirect |-> !res.target[0])
		else $error("redirect to odd target %h", res.target);

endmodule

`default_nettype wire

//--- hdl/exec_unit.sv
`default_nettype none

module exec_unit (
	input  wire                     CLK,
	input  wire                     rst,
	input  wire                     in_valid,
	input  wire rv_pkg::inst_u      inst,
	input  wire [rv_pkg::pc_w-1:0]  pc,
	input  wire [rv_pkg::xlen-1:0]  rs1_data,
	input  wire [rv_pkg::xlen-1:0]  rs2_data,
	output logic                    out_valid,
	output rv_pkg::result_t         res
);
	import rv_pkg::*;

	ctrl_t           ctrl;		// Decoder to EXE
	logic [xlen-1:0] imm;		// Sign-extended immediate

	//////////////////////////////
	// Decode, both read the same word
	inst_decoder u_dec (
		.inst (inst),
		.ctrl (ctrl)
	);

	imm_gen u_imm (
		.inst    (inst),
		.imm_sel (ctrl.imm_sel),	// Format from the decoder
		.imm     (imm)
	);

	// Two-cycle execute
	exe_stage u_exe (
		.CLK       (CLK),
		.rst       (rst),
		.in_valid  (in_valid),
		.ctrl      (ctrl),
		.imm       (imm),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.pc        (pc),
		.rd        (inst.r_fmt.rd),
		.out_valid (out_valid),
		.res       (res)
	);

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`default_nettype none

module tb_clock #(
	parameter int half_ns    = 2,	// 4 ns period
	parameter int rst_cycles = 4
) (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	initial clk = 1'b0;
	always #(half_ns) clk = ~clk;

	initial begin
		rst = 1'b1;
		repeat (rst_cycles) @(posedge clk);
		rst <= 1'b0;	// Released on an edge
	end
endmodule

`default_nettype wire

//--- test/tb_exec_unit.sv
`default_nettype none

module tb_exec_unit;
	timeunit 1ns;
	timeprecision 100ps;
	import rv_pkg::*;

	localparam int n_r     = 300;
	localparam int n_i     = 240;	// 160 OP-IMM, 80 LUI/AUIPC
	localparam int n_b     = 72;
	localparam int n_j     = 40;
	localparam int n_tp    = 200;
	localparam int n_ill   = 60;
	localparam int drain_n = 4;
	localparam int slots   = n_r + n_i + n_b + n_j + n_tp + n_ill + 6 * drain_n + 8;
	localparam int limit_ns = slots * 4 + 200;

	typedef struct packed {
		logic    valid;
		logic    chk_data;	// wr_data defined
		logic    chk_tgt;	// target defined
		result_t r;
	} exp_t;

	logic            CLK, rst, in_valid;
	inst_u           inst;
	logic [pc_w-1:0] pc;
	logic [xlen-1:0] rs1_data, rs2_data;
	logic            out_valid;
	result_t         res;
	exp_t            cur_exp, dl_a, dl_b;	// Inputs on the pins, then two stages
	logic            armed;
	int              errors, checks, err_mark, chk_mark;
	logic [2:0] branch_conds [6] = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
	logic [31:0] pair_a [6] = '{32'd5, 32'd3, 32'd7, 32'hffff_ffff, 32'd1, 32'h8000_0000};
	logic [31:0] pair_b [6] = '{32'd5, 32'd7, 32'd3, 32'd1, 32'hffff_ffff, 32'h7fff_ffff};

	tb_clock #(.half_ns(2), .rst_cycles(4)) u_clk (.clk(CLK), .rst(rst));

	exec_unit u_dut (
		.CLK       (CLK),
		.rst       (rst),
		.in_valid  (in_valid),
		.inst      (inst),
		.pc        (pc),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.out_valid (out_valid),
		.res       (res)
	);

	//////////////////////////////
	// Reference model
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				else
					return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic exp_t expect_result(input logic [31:0] w, input logic [pc_w-1:0] p,
			input logic [31:0] a, input logic [31:0] b);
		exp_t        e;
		logic [31:0] imm_i, imm_b, imm_u, imm_j, sum;
		logic [6:0]  f7;
		logic [2:0]  f3;
		logic        wr;
		e = '0;
		e.valid = 1'b1;
		f7 = w[31:25];
		f3 = w[14:12];
		wr = 1'b0;
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		imm_u = {w[31:12], 12'h000};
		imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		e.r.rd = w[11:7];
		case (w[6:0])
			op_op: begin
				e.r.illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
				e.r.wr_data = alu_ref(f3, f7[5], a, b);
				wr = 1'b1;
			end
			op_imm: begin
				if (f3 == 3'd1)
					e.r.illegal = (f7 != 7'h00);	// slli
				else if (f3 == 3'd5)
					e.r.illegal = (f7 != 7'h00 && f7 != 7'h20);
				e.r.wr_data = alu_ref(f3, f3 == 3'd5 && f7[5], a, imm_i);
				wr = 1'b1;
			end
			op_lui: begin
				e.r.wr_data = imm_u;
				wr = 1'b1;
			end
			op_auipc: begin
				e.r.wr_data = {20'b0, p} + imm_u;
				wr = 1'b1;
			end
			op_branch: begin
				case (f3)
					3'd0: e.r.redirect = (a == b);
					3'd1: e.r.redirect = (a != b);
					3'd4: e.r.redirect = ($signed(a) < $signed(b));
					3'd5: e.r.redirect = ($signed(a) >= $signed(b));
					3'd6: e.r.redirect = (a < b);
					3'd7: e.r.redirect = (a >= b);
					default: e.r.redirect = 1'b0;
				endcase
				e.r.target = p + imm_b[pc_w-1:0];
			end
			op_jal, op_jalr: begin
				e.r.wr_data = {20'b0, p + 12'd4};	// Link wraps in pc_w
				e.r.redirect = 1'b1;
				sum = a + imm_i;
				if (w[6:0] == op_jal)
					e.r.target = p + imm_j[pc_w-1:0];
				else
					e.r.target = {sum[pc_w-1:1], 1'b0};
				wr = 1'b1;
			end
			default: e.r.illegal = 1'b1;
		endcase
		e.r.wr_en = wr && e.r.rd != 5'd0 && !e.r.illegal;
		e.chk_data = wr && !e.r.illegal;
		e.chk_tgt = e.r.redirect;
		return e;
	endfunction

	//////////////////////////////
	// Instruction builders
	function automatic logic [31:0] r_word(input logic [2:0] f3, input logic alt,
			input logic [4:0] rd);
		return {alt ? f7_alt : f7_base, 5'($urandom), 5'($urandom), f3, rd, op_op};
	endfunction

	function automatic logic [31:0] i_word(input logic [2:0] f3, input logic [4:0] rd,
			input logic neg);
		logic [11:0] imm;
		imm = 12'($urandom);
		imm[11] = neg;
		if (f3 == f3_sll)
			imm[11:5] = f7_base;
		else if (f3 == f3_srl)
			imm[11:5] = neg ? f7_alt : f7_base;	// srai or srli
		return {imm, 5'($urandom), f3, rd, op_imm};
	endfunction

	function automatic logic [31:0] b_word(input logic [2:0] f3, input logic neg);
		logic [12:0] off;
		off = 13'($urandom);
		off[0] = 1'b0;
		off[12] = neg;
		return {off[12], off[10:5], 5'($urandom), 5'($urandom), f3, off[4:1], off[11], op_branch};
	endfunction

	function automatic logic [31:0] j_word(input logic [4:0] rd, input logic neg);
		logic [20:0] off;
		off = 21'($urandom);
		off[20] = neg;
		return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
	endfunction

	function automatic logic [31:0] random_word();
		logic [2:0] f3;
		f3 = 3'($urandom);
		case ($urandom % 5)
			0: return r_word(f3, f3 == f3_add && $urandom % 2 == 1, 5'($urandom));
			1: return i_word(f3, 5'($urandom), f3[0]);
			2: return b_word(branch_conds[f3 % 6], f3[1]);
			3: return j_word(5'($urandom), f3[2]);
			default: return {20'($urandom), 5'($urandom), op_lui};
		endcase
	endfunction

	function automatic logic [31:0] illegal_word(input int sel);
		logic [6:0] opc;
		logic [6:0] f7;
		logic [2:0] f3;
		f7 = 7'($urandom) | 7'h01;	// Never 0x00 or 0x20
		f3 = 3'($urandom);
		case (sel % 4)
			0: begin
				do
					opc = 7'($urandom);
				while (opc inside {op_op, op_imm, op_lui, op_auipc, op_branch, op_jal, op_jalr});
				return {25'($urandom), opc};
			end
			1: return {f7, 10'($urandom), f3, 5'($urandom), op_op};
			2: return {f7_alt, 10'($urandom), f3 | 3'b010, 5'($urandom), op_op};	// No alt form
			default: return {f7, 10'($urandom), f3[2] ? f3_srl : f3_sll, 5'($urandom), op_imm};
		endcase
	endfunction

	//////////////////////////////
	// Stimulus helpers
	task automatic issue(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b,
			input logic v);
		logic [pc_w-1:0] p;
		exp_t            e;
		p = pc_w'($urandom << 2);	// Word aligned
		e = expect_result(w, p, a, b);
		e.valid = v;
		@(posedge CLK);
		in_valid <= v;
		inst <= w;
		pc <= p;
		rs1_data <= a;
		rs2_data <= b;
		cur_exp <= e;
	endtask

	task automatic close_test(input string name);
		repeat (drain_n) issue(32'h0000_0013, 32'd0, 32'd0, 1'b0);
		$display("%-12s %4d results %3d errors", name, checks - chk_mark, errors - err_mark);
		err_mark = errors;
		chk_mark = checks;
	endtask

	task automatic compare_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("error %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	//////////////////////////////
	// Delay line and compare
	always @(posedge CLK) begin
		armed <= 1'b1;
		if (rst) begin
			dl_a <= '0;
			dl_b <= '0;
		end else begin
			dl_a <= cur_exp;	// Sampled by the DUT on this edge
			dl_b <= dl_a;
		end
	end

	always @(negedge CLK) begin
		if (armed) begin
			assert (out_valid === dl_b.valid) else begin
				$display("error out_valid: got %h expected %h", out_valid, dl_b.valid);
				errors++;
			end
			if (dl_b.valid && out_valid) begin
				checks++;
				compare_field("rd", 32'(res.rd), 32'(dl_b.r.rd));
				compare_field("wr_en", 32'(res.wr_en), 32'(dl_b.r.wr_en));
				compare_field("redirect", 32'(res.redirect), 32'(dl_b.r.redirect));
				compare_field("illegal", 32'(res.illegal), 32'(dl_b.r.illegal));
				if (dl_b.chk_data)
					compare_field("wr_data", res.wr_data, dl_b.r.wr_data);
				if (dl_b.chk_tgt)
					compare_field("target", 32'(res.target), 32'(dl_b.r.target));
			end else if (!dl_b.valid) begin
				compare_field("wr_en", 32'(res.wr_en), 32'd0);	// Idle slot stays inert
				compare_field("redirect", 32'(res.redirect), 32'd0);
			end
		end
	end

	// Watchdog
	initial begin
		#(limit_ns * 1ns);
		$display("timeout: the run did not finish within %0d ns", limit_ns);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		logic [2:0] f3;
		void'($urandom(92121));
		in_valid = 1'b0;
		inst = '0;
		pc = '0;
		rs1_data = '0;
		rs2_data = '0;
		cur_exp = '0;
		armed = 1'b0;
		errors = 0;
		checks = 0;
		err_mark = 0;
		chk_mark = 0;
		wait (rst === 1'b0);

		for (int i = 0; i < n_r; i++) begin
			f3 = 3'($urandom);
			issue(r_word(f3, (f3 == f3_add || f3 == f3_srl) && $urandom % 2 == 1,
				(i % 16 == 0) ? 5'd0 : 5'($urandom)), $urandom, $urandom, 1'b1);
		end
		close_test("r_type");

		for (int i = 0; i < 160; i++)
			issue(i_word(3'($urandom), 5'($urandom), i[0]), $urandom, 32'd0, 1'b1);
		for (int i = 0; i < n_i - 160; i++)
			issue({i[1], 19'($urandom), 5'($urandom), i[0] ? op_lui : op_auipc},
				$urandom, 32'd0, 1'b1);
		close_test("immediates");

		for (int rep = 0; rep < 2; rep++)
			for (int c = 0; c < 6; c++)
				for (int p = 0; p < 6; p++)
					issue(b_word(branch_conds[c], rep[0]), pair_a[p], pair_b[p], 1'b1);
		close_test("branches");

		for (int i = 0; i < n_j; i++) begin
			if (i % 2 == 1)
				issue(j_word(5'($urandom), i[1]), $urandom, 32'd0, 1'b1);
			else
				issue({12'($urandom), 5'($urandom), 3'b000, 5'($urandom), op_jalr},
					$urandom, 32'd0, 1'b1);	// Odd rs1 too
		end
		close_test("jumps");

		// Gaps on about a quarter of the slots
		for (int i = 0; i < n_tp; i++)
			issue(random_word(), $urandom, $urandom, $urandom % 4 != 0);
		close_test("throughput");

		for (int i = 0; i < n_ill; i++)
			issue(illegal_word(i), $urandom, $urandom, 1'b1);
		close_test("illegal");

		$display("tests 6, results checked %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- exec_unit.f
hdl/rv_pkg.sv
hdl/alu.sv
hdl/inst_decoder.sv
hdl/imm_gen.sv
hdl/exe_stage.sv
hdl/exec_unit.sv
test/tb_clock.sv
test/tb_exec_unit.sv

//--- Makefile
# Verilator build and run of the exec_unit testbench

VERILATOR ?= verilator
TOP       ?= tb_exec_unit
FLIST     ?= exec_unit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= >>> PASS

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Overridable: VERILATOR TOP FLIST BUILD_DIR VFLAGS PASS_MSG"

$(SIM): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
